// File: all.f
verilog/cpu_pkg.sv
verilog/cpu_if.sv
verilog/alu.sv
verilog/regfile.sv
verilog/inst_decoder.sv
verilog/cpu_control.sv
verilog/cpu_datapath.sv
verilog/mycpu_top.sv
testbench/tb_memory.sv
testbench/tb_mycpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mycpu -f all.f -o sim_tb_mycpu &&
./obj_dir/sim_tb_mycpu | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/tb_memory.sv
`default_nettype none

// word memories for instructions and data, one cycle read latency
module tb_memory #(
    parameter logic [31:0] inst_base = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    input  logic        data_we,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] inst_offs;

    assign inst_offs = inst_addr - inst_base;

    initial begin
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
            dmem[i] = {16'hd0d0, 6'b0, i[7:0], 2'b00};   // tagged with own address
        end
    end

    always @(posedge clk) begin
        inst_rdata <= imem[inst_offs[9:2]];
        data_rdata <= dmem[data_addr[9:2]];
        if (data_we) begin
            dmem[data_addr[9:2]] <= data_wdata;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_mycpu.sv
`default_nettype none

module tb_mycpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;
    localparam int max_cycles = 1300;
    localparam logic [4:0] rr_funcs [0:7] = '{5'h00, 5'h02, 5'h04, 5'h05,
                                              5'h08, 5'h09, 5'h0a, 5'h0b};

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_rdata;
    logic [31:0] inst_sram_addr;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    integer      seed = 32'h5557_fccf;
    int          cycles = 0;
    int          fail_count = 0;
    logic [31:0] end_pc;
    logic [31:0] gpr [0:31];     // reference register file
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$], exp_num [$], exp_data [$];
    logic [31:0] got_pc [$], got_num [$], got_data [$];
    logic [31:0] exp_st_addr [$], exp_st_data [$];
    logic [31:0] got_st_addr [$], got_st_data [$];

    mycpu_top #(.reset_pc(reset_pc)) UUT (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_rdata   (data_sram_rdata),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_memory #(.inst_base(reset_pc)) mem (
        .clk        (clk),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the program never reached its final self-branch");
            $display("Test failures found");
            $fatal(1);
        end
    end

    // trace and store monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (data_sram_we) begin
                $display("data_sram_we went high during reset at %0t", $time);
                $display("Test failures found");
                $fatal(1);
            end
        end else begin
            if (debug_wb_rf_we) begin
                got_pc.push_back(debug_wb_pc);
                got_num.push_back({27'b0, debug_wb_rf_wnum});
                got_data.push_back(debug_wb_rf_wdata);
            end
            if (data_sram_we) begin
                got_st_addr.push_back(data_sram_addr);
                got_st_data.push_back(data_sram_wdata);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_count++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // ############################################################
    // instruction encoders
    // ############################################################

    function automatic logic [31:0] enc_3r(input logic [4:0] f, rd, rj, rk);
        return {12'h001, f, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_shift(input logic [4:0] f, rd, rj, ui5);
        return {12'h004, f, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, rj, input logic [11:0] si12);
        return {10'h00a, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    function automatic logic [31:0] enc_mem(input logic store, input logic [4:0] rd, rj,
                                            input logic [11:0] si12);
        return {(store ? 10'h0a6 : 10'h0a2), si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_br16(input logic [5:0] op, input logic [4:0] rj, rd,
                                             input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_b26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] ref_3r(input logic [4:0] f, input logic [31:0] x, y);
        case (f)
            5'h00:   return x + y;
            5'h02:   return x - y;
            5'h04:   return (x[31] != y[31]) ? {31'b0, x[31]} : {31'b0, x < y};
            5'h05:   return {31'b0, x < y};
            5'h08:   return ~(x | y);
            5'h09:   return x & y;
            5'h0a:   return x | y;
            default: return x ^ y;
        endcase
    endfunction

    function automatic logic [31:0] next_pc();
        return reset_pc + 32'(4 * prog.size());
    endfunction

    // ############################################################
    // program building and running
    // ############################################################

    task automatic start_prog();
        prog.delete();
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
    endtask

    // instruction that writes a register, with its predicted trace record
    task automatic put_wr(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] value);
        exp_pc.push_back(next_pc());
        exp_num.push_back({27'b0, rd});
        exp_data.push_back(value);
        prog.push_back(word);
        if (rd != 5'd0) gpr[rd] = value;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;    // compensates the sign of the low part
        put_wr(enc_lu12i(rd, hi[31:12]), rd, {hi[31:12], 12'h0});
        put_wr(enc_addi(rd, rd, v[11:0]), rd, gpr[rd] + {{20{v[11]}}, v[11:0]});
    endtask

    task automatic finish_prog();
        end_pc = next_pc();
        prog.push_back(enc_b26(6'h14, 26'd0));
    endtask

    task automatic run_prog(input string name);
        logic done;
        done = 1'b0;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < prog.size(); i++) mem.imem[i] = prog[i];
        repeat (4) @(posedge clk);
        got_pc.delete();
        got_num.delete();
        got_data.delete();
        got_st_addr.delete();
        got_st_data.delete();
        reset <= 1'b0;
        @(negedge clk);
        check_value("inst_sram_addr", reset_pc, inst_sram_addr);   // first fetch
        while (!done) begin
            @(negedge clk);
            done = !reset && inst_sram_addr == end_pc;
        end
        check_value({name, " trace count"}, exp_pc.size(), got_pc.size());
        for (int i = 0; i < exp_pc.size(); i++) begin
            check_value("debug_wb_pc", exp_pc[i], got_pc[i]);
            check_value("debug_wb_rf_wnum", exp_num[i], got_num[i]);
            check_value("debug_wb_rf_wdata", exp_data[i], got_data[i]);
        end
        check_value({name, " store count"}, exp_st_addr.size(), got_st_addr.size());
        for (int i = 0; i < exp_st_addr.size(); i++) begin
            check_value("data_sram_addr", exp_st_addr[i], got_st_addr[i]);
            check_value("data_sram_wdata", exp_st_data[i], got_st_data[i]);
        end
    endtask

    // ############################################################
    // directed tests
    // ############################################################

    task automatic test_reg_reg();
        start_prog();
        load_const(5'd4, $random(seed));
        load_const(5'd5, $random(seed));
        for (int i = 0; i < 8; i++) begin
            put_wr(enc_3r(rr_funcs[i], 5'(6 + i), 5'd4, 5'd5), 5'(6 + i),
                   ref_3r(rr_funcs[i], gpr[4], gpr[5]));
        end
        finish_prog();
        run_prog("reg_reg");
    endtask

    task automatic test_imm_shift();
        start_prog();
        load_const(5'd4, $random(seed) | 32'h8000_0000);    // negative operand
        put_wr(enc_addi(5'd5, 5'd4, 12'hffb), 5'd5, gpr[4] - 32'd5);
        put_wr(enc_lu12i(5'd6, 20'h81234), 5'd6, 32'h8123_4000);
        put_wr(enc_shift(5'h01, 5'd7, 5'd4, 5'd3), 5'd7, {gpr[4][28:0], 3'b000});
        put_wr(enc_shift(5'h09, 5'd8, 5'd4, 5'd7), 5'd8, {7'b0, gpr[4][31:7]});
        put_wr(enc_shift(5'h11, 5'd9, 5'd4, 5'd7), 5'd9, {{7{gpr[4][31]}}, gpr[4][31:7]});
        finish_prog();
        run_prog("imm_shift");
    endtask

    task automatic test_memory();
        start_prog();
        load_const(5'd4, 32'h0000_0080);
        load_const(5'd5, $random(seed));
        prog.push_back(enc_mem(1'b1, 5'd5, 5'd4, 12'd12));
        exp_st_addr.push_back(gpr[4] + 32'd12);
        exp_st_data.push_back(gpr[5]);
        put_wr(enc_mem(1'b0, 5'd6, 5'd4, 12'd12), 5'd6, gpr[5]);
        finish_prog();
        run_prog("memory");
    endtask

    task automatic test_branches();
        start_prog();
        put_wr(enc_addi(5'd4, 5'd0, 12'd5), 5'd4, 32'd5);
        put_wr(enc_addi(5'd5, 5'd0, 12'd5), 5'd5, 32'd5);
        put_wr(enc_addi(5'd6, 5'd0, 12'd7), 5'd6, 32'd7);
        prog.push_back(enc_br16(6'h16, 5'd4, 5'd5, 16'd2));   // beq taken
        prog.push_back(enc_addi(5'd10, 5'd0, 12'd1));
        put_wr(enc_addi(5'd11, 5'd0, 12'd2), 5'd11, 32'd2);
        prog.push_back(enc_br16(6'h16, 5'd4, 5'd6, 16'd2));   // beq falls through
        put_wr(enc_addi(5'd12, 5'd0, 12'd3), 5'd12, 32'd3);
        prog.push_back(enc_br16(6'h17, 5'd4, 5'd6, 16'd2));   // bne taken
        prog.push_back(enc_addi(5'd13, 5'd0, 12'd4));
        put_wr(enc_addi(5'd14, 5'd0, 12'd5), 5'd14, 32'd5);
        prog.push_back(enc_br16(6'h17, 5'd4, 5'd5, 16'd2));   // bne falls through
        put_wr(enc_addi(5'd15, 5'd0, 12'd6), 5'd15, 32'd6);
        prog.push_back(enc_b26(6'h14, 26'd2));
        prog.push_back(enc_addi(5'd16, 5'd0, 12'd7));
        put_wr(enc_addi(5'd17, 5'd0, 12'd8), 5'd17, 32'd8);
        finish_prog();
        run_prog("branches");
    endtask

    task automatic test_links();
        logic [31:0] jpc;
        start_prog();
        put_wr(enc_b26(6'h15, 26'd3), 5'd1, next_pc() + 32'd4);    // bl
        prog.push_back(enc_addi(5'd7, 5'd0, 12'd1));
        prog.push_back(enc_addi(5'd7, 5'd0, 12'd2));
        put_wr(enc_addi(5'd7, 5'd0, 12'd9), 5'd7, 32'd9);
        jpc = next_pc() + 32'd8;    // jirl sits after the two constant words
        load_const(5'd8, jpc);
        put_wr(enc_br16(6'h13, 5'd8, 5'd9, 16'd2), 5'd9, jpc + 32'd4);
        prog.push_back(enc_addi(5'd10, 5'd0, 12'd1));
        put_wr(enc_addi(5'd10, 5'd0, 12'd3), 5'd10, 32'd3);
        finish_prog();
        run_prog("links");
    endtask

    task automatic test_zero_reg();
        start_prog();
        put_wr(enc_addi(5'd0, 5'd0, 12'h123), 5'd0, 32'h123);
        put_wr(enc_3r(5'h00, 5'd4, 5'd0, 5'd0), 5'd4, gpr[0] + gpr[0]);
        put_wr(enc_addi(5'd5, 5'd0, 12'd7), 5'd5, 32'd7);
        finish_prog();
        run_prog("zero_reg");
    endtask

    initial begin
        reset = 1'b1;
        for (int i = 0; i < 32; i++) gpr[i] = 32'h0;
        test_zero_reg();
        test_reg_reg();
        test_imm_shift();
        test_memory();
        test_branches();
        test_links();
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  alu_op_t         op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result
);

    logic [4:0]      shamt;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt       = src2[4:0];
    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_slt:  result = {31'b0, lt_signed};
            alu_sltu: result = {31'b0, lt_unsigned};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $unsigned($signed(src1) >>> shamt);
            alu_lui:  result = src2;    // upper immediate already shifted
            default:  result = sum;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cpu_control.sv
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic reset,
    dec_if.ctl   dec,
    ctl_if.ctl   ctl
);

    cpu_state_t state;
    cpu_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= if_s;
        end else begin
            state <= state_next;
        end
    end

    // ##########################################################
    // phase sequencing and strobes
    // ##########################################################

    always_comb begin
        state_next    = if_s;
        ctl.ir_load   = 1'b0;
        ctl.res_load  = 1'b0;
        ctl.pc_load   = 1'b0;
        ctl.mem_write = 1'b0;
        ctl.wb_write  = 1'b0;
        case (state)
            if_s: state_next = id_s;
            id_s: begin
                ctl.ir_load = 1'b1;      // fetch data is on the bus now
                state_next  = exe_s;
            end
            exe_s: begin
                ctl.res_load = 1'b1;
                case (dec.inst_class)
                    cls_branch: ctl.pc_load = 1'b1;   // branch ends here
                    cls_load,
                    cls_store:  state_next = mem_s;
                    default:    state_next = wb_s;
                endcase
            end
            mem_s: begin
                if (dec.inst_class == cls_store) begin
                    ctl.mem_write = 1'b1;
                    ctl.pc_load   = 1'b1;
                end else begin
                    state_next = wb_s;
                end
            end
            wb_s: begin
                ctl.wb_write = 1'b1;
                ctl.pc_load  = 1'b1;
            end
            default: ;
        endcase
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset) state inside {if_s, id_s, exe_s, mem_s, wb_s}
    );

endmodule

`default_nettype wire

// File: verilog/cpu_datapath.sv
`default_nettype none

module cpu_datapath
    import cpu_pkg::*;
#(
    parameter logic [xlen-1:0] reset_pc = 32'h1c00_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] inst_sram_rdata,
    input  logic [xlen-1:0] data_sram_rdata,
    dec_if.dp               dec,
    ctl_if.dp               ctl,
    rf_if.dp                rf,
    output inst_t           inst,
    output logic [xlen-1:0] inst_sram_addr,
    output logic            data_sram_we,
    output logic [xlen-1:0] data_sram_addr,
    output logic [xlen-1:0] data_sram_wdata,
    output logic [xlen-1:0] debug_wb_pc,
    output logic            debug_wb_rf_we,
    output reg_addr_t       debug_wb_rf_wnum,
    output logic [xlen-1:0] debug_wb_rf_wdata
);

    logic [xlen-1:0] pc;
    inst_t           ir;
    logic [xlen-1:0] res_q;
    logic            br_taken_q;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic            br_taken_c;
    logic            br_taken;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= reset_pc;
            br_taken_q <= 1'b0;
        end else begin
            if (ctl.pc_load)  pc <= pc_next;
            if (ctl.res_load) br_taken_q <= br_taken_c;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.ir_load)  ir <= inst_sram_rdata;
        if (ctl.res_load) res_q <= alu_result;
    end

    // ##########################################################
    // operands and branch resolution
    // ##########################################################

    assign rf.raddr1 = dec.raddr1;
    assign rf.raddr2 = dec.raddr2;

    assign alu_src1 = dec.src1_is_pc ? pc : rf.rdata1;

    always_comb begin
        case (dec.src2_sel)
            src2_imm:  alu_src2 = dec.imm;
            src2_four: alu_src2 = 32'd4;
            default:   alu_src2 = rf.rdata2;
        endcase
    end

    alu u_alu (
        .op     (dec.op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    always_comb begin
        case (dec.br_kind)
            br_beq:    br_taken_c = rf.rdata1 == rf.rdata2;
            br_bne:    br_taken_c = rf.rdata1 != rf.rdata2;
            br_always,
            br_jirl:   br_taken_c = 1'b1;
            default:   br_taken_c = 1'b0;
        endcase
    end

    // link instructions end in wb, so use the flag saved in exe
    assign br_taken  = ctl.res_load ? br_taken_c : br_taken_q;
    assign br_target = (dec.br_kind == br_jirl) ? rf.rdata1 + dec.br_offs : pc + dec.br_offs;
    assign pc_next   = br_taken ? br_target : pc + 32'd4;

    // write back
    assign wb_data  = (dec.inst_class == cls_load) ? data_sram_rdata : res_q;
    assign rf.we    = ctl.wb_write & dec.gr_we;
    assign rf.waddr = dec.dest;
    assign rf.wdata = wb_data;

    assign inst            = ir;
    assign inst_sram_addr  = pc;
    assign data_sram_we    = ctl.mem_write;
    assign data_sram_addr  = res_q;          // address latched in exe
    assign data_sram_wdata = rf.rdata2;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf.we;
    assign debug_wb_rf_wnum  = dec.dest;
    assign debug_wb_rf_wdata = wb_data;

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/cpu_if.sv
`default_nettype none

// decoder outputs, read by datapath and control
interface dec_if
    import cpu_pkg::*;
();
    alu_op_t         op;
    logic            src1_is_pc;
    src2_sel_t       src2_sel;
    logic [xlen-1:0] imm;
    br_kind_t        br_kind;
    logic [xlen-1:0] br_offs;
    reg_addr_t       raddr1;
    reg_addr_t       raddr2;
    reg_addr_t       dest;
    logic            gr_we;
    inst_class_t     inst_class;

    modport dec (output op, src1_is_pc, src2_sel, imm, br_kind, br_offs,
                 raddr1, raddr2, dest, gr_we, inst_class);
    modport dp  (input op, src1_is_pc, src2_sel, imm, br_kind, br_offs,
                 raddr1, raddr2, dest, gr_we, inst_class);
    modport ctl (input inst_class);
endinterface

// phase strobes from the FSM
interface ctl_if;
    logic ir_load;
    logic res_load;
    logic pc_load;
    logic mem_write;
    logic wb_write;

    modport ctl (output ir_load, res_load, pc_load, mem_write, wb_write);
    modport dp  (input ir_load, res_load, pc_load, mem_write, wb_write);
endinterface

interface rf_if
    import cpu_pkg::*;
();
    reg_addr_t       raddr1;
    reg_addr_t       raddr2;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic            we;
    reg_addr_t       waddr;
    logic [xlen-1:0] wdata;

    modport dp (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
    modport rf (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);
endinterface

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // one instruction word, several field layouts
    typedef union packed {
        struct packed {
            logic [5:0] op_31_26;
            logic [3:0] op_25_22;
            logic [1:0] op_21_20;
            logic [4:0] op_19_15;
            reg_addr_t  rk;
            reg_addr_t  rj;
            reg_addr_t  rd;
        } fmt_3r;
        struct packed {
            logic [5:0]  op_31_26;
            logic [3:0]  op_25_22;
            logic [11:0] i12;
            reg_addr_t   rj;
            reg_addr_t   rd;
        } fmt_2ri12;
        struct packed {
            logic [6:0]  op_31_25;
            logic [19:0] i20;
            reg_addr_t   rd;
        } fmt_1ri20;
        struct packed {
            logic [5:0]  op_31_26;
            logic [15:0] i16;
            reg_addr_t   rj;
            reg_addr_t   rd;
        } fmt_2ri16;
        struct packed {
            logic [5:0]  op_31_26;
            logic [15:0] offs_lo;   // offset bits 15:0
            logic [9:0]  offs_hi;   // offset bits 25:16
        } fmt_i26;
    } inst_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {src2_reg, src2_imm, src2_four} src2_sel_t;

    typedef enum logic [2:0] {br_none, br_beq, br_bne, br_always, br_jirl} br_kind_t;

    typedef enum logic [2:0] {if_s, id_s, exe_s, mem_s, wb_s} cpu_state_t;

    typedef enum logic [2:0] {cls_alu, cls_load, cls_store, cls_branch, cls_link} inst_class_t;

endpackage

`default_nettype wire

// File: verilog/inst_decoder.sv
`default_nettype none

module inst_decoder
    import cpu_pkg::*;
(
    input  inst_t inst,
    dec_if.dec    dec
);

    logic            grp_3r;
    logic            grp_shift;
    alu_op_t         op;
    logic            src1_is_pc;
    src2_sel_t       src2_sel;
    br_kind_t        br_kind;
    inst_class_t     cls;
    logic            raddr2_is_rd;
    logic            dest_is_r1;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] si12;
    logic [xlen-1:0] ui5;
    logic [xlen-1:0] ui20;
    logic [xlen-1:0] offs16;
    logic [xlen-1:0] offs26;

    assign grp_3r    = inst.fmt_3r.op_31_26 == 6'h00 && inst.fmt_3r.op_25_22 == 4'h0
                       && inst.fmt_3r.op_21_20 == 2'h1;
    assign grp_shift = inst.fmt_3r.op_31_26 == 6'h00 && inst.fmt_3r.op_25_22 == 4'h1
                       && inst.fmt_3r.op_21_20 == 2'h0;

    // immediate forms
    assign si12   = {{20{inst.fmt_2ri12.i12[11]}}, inst.fmt_2ri12.i12};
    assign ui5    = {27'b0, inst.fmt_3r.rk};
    assign ui20   = {inst.fmt_1ri20.i20, 12'b0};
    assign offs16 = {{14{inst.fmt_2ri16.i16[15]}}, inst.fmt_2ri16.i16, 2'b00};
    assign offs26 = {{4{inst.fmt_i26.offs_hi[9]}}, inst.fmt_i26.offs_hi,
                     inst.fmt_i26.offs_lo, 2'b00};

    always_comb begin
        op           = alu_add;
        src1_is_pc   = 1'b0;
        src2_sel     = src2_reg;
        imm          = si12;
        br_kind      = br_none;
        cls          = cls_branch;     // unknown word just steps the pc
        raddr2_is_rd = 1'b0;
        dest_is_r1   = 1'b0;
        if (grp_3r) begin
            cls = cls_alu;
            case (inst.fmt_3r.op_19_15)
                5'h00:   op = alu_add;
                5'h02:   op = alu_sub;
                5'h04:   op = alu_slt;
                5'h05:   op = alu_sltu;
                5'h08:   op = alu_nor;
                5'h09:   op = alu_and;
                5'h0a:   op = alu_or;
                5'h0b:   op = alu_xor;
                default: cls = cls_branch;
            endcase
        end else if (grp_shift) begin
            cls      = cls_alu;
            src2_sel = src2_imm;
            imm      = ui5;
            case (inst.fmt_3r.op_19_15)
                5'h01:   op = alu_sll;
                5'h09:   op = alu_srl;
                5'h11:   op = alu_sra;
                default: cls = cls_branch;
            endcase
        end else if (inst.fmt_2ri12.op_31_26 == 6'h00 && inst.fmt_2ri12.op_25_22 == 4'ha) begin
            cls      = cls_alu;           // addi.w
            src2_sel = src2_imm;
        end else if (inst.fmt_1ri20.op_31_25 == 7'h0a) begin
            cls      = cls_alu;           // lu12i.w
            op       = alu_lui;
            src2_sel = src2_imm;
            imm      = ui20;
        end else if (inst.fmt_2ri12.op_31_26 == 6'h0a && inst.fmt_2ri12.op_25_22 == 4'h2) begin
            cls      = cls_load;
            src2_sel = src2_imm;
        end else if (inst.fmt_2ri12.op_31_26 == 6'h0a && inst.fmt_2ri12.op_25_22 == 4'h6) begin
            cls          = cls_store;
            src2_sel     = src2_imm;
            raddr2_is_rd = 1'b1;
        end else begin
            case (inst.fmt_2ri16.op_31_26)
                6'h13: begin                  // jirl
                    cls        = cls_link;
                    br_kind    = br_jirl;
                    src1_is_pc = 1'b1;
                    src2_sel   = src2_four;
                end
                6'h14: br_kind = br_always;   // b
                6'h15: begin                  // bl
                    cls        = cls_link;
                    br_kind    = br_always;
                    src1_is_pc = 1'b1;
                    src2_sel   = src2_four;
                    dest_is_r1 = 1'b1;
                end
                6'h16: begin
                    br_kind      = br_beq;
                    raddr2_is_rd = 1'b1;
                end
                6'h17: begin
                    br_kind      = br_bne;
                    raddr2_is_rd = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign dec.op         = op;
    assign dec.src1_is_pc = src1_is_pc;
    assign dec.src2_sel   = src2_sel;
    assign dec.imm        = imm;
    assign dec.br_kind    = br_kind;
    assign dec.br_offs    = (inst.fmt_i26.op_31_26 inside {6'h14, 6'h15}) ? offs26 : offs16;
    assign dec.raddr1     = inst.fmt_3r.rj;
    assign dec.raddr2     = raddr2_is_rd ? inst.fmt_3r.rd : inst.fmt_3r.rk;
    assign dec.dest       = dest_is_r1 ? 5'd1 : inst.fmt_3r.rd;
    assign dec.gr_we      = cls inside {cls_alu, cls_load, cls_link};
    assign dec.inst_class = cls;

endmodule

`default_nettype wire

// File: verilog/mycpu_top.sv
`default_nettype none

module mycpu_top
    import cpu_pkg::*;
#(
    parameter logic [xlen-1:0] reset_pc = 32'h1c00_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] inst_sram_rdata,
    input  logic [xlen-1:0] data_sram_rdata,
    output logic [xlen-1:0] inst_sram_addr,
    output logic            data_sram_we,
    output logic [xlen-1:0] data_sram_addr,
    output logic [xlen-1:0] data_sram_wdata,
    output logic [xlen-1:0] debug_wb_pc,
    output logic            debug_wb_rf_we,
    output reg_addr_t       debug_wb_rf_wnum,
    output logic [xlen-1:0] debug_wb_rf_wdata
);

    inst_t inst;     // instruction register contents

    dec_if u_dec_if ();
    ctl_if u_ctl_if ();
    rf_if  u_rf_if ();

    cpu_control u_control (
        .clk   (clk),
        .reset (reset),
        .dec   (u_dec_if.ctl),
        .ctl   (u_ctl_if.ctl)
    );

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (u_dec_if.dec)
    );

    cpu_datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_rdata   (data_sram_rdata),
        .dec               (u_dec_if.dp),
        .ctl               (u_ctl_if.dp),
        .rf                (u_rf_if.dp),
        .inst              (inst),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    regfile u_regfile (
        .clk (clk),
        .rf  (u_rf_if.rf)
    );

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`default_nettype none

module regfile
    import cpu_pkg::*;
(
    input  logic clk,
    rf_if.rf     rf
);

    logic [xlen-1:0] regs [1:31];    // no storage for r0

    always_ff @(posedge clk) begin
        if (rf.we && rf.waddr != 5'd0) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    assign rf.rdata1 = (rf.raddr1 == 5'd0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == 5'd0) ? '0 : regs[rf.raddr2];

    // r0 stays zero even right after a write aimed at it
    a_r0_zero: assert property (
        @(posedge clk) rf.we && rf.waddr == 5'd0 ##1 rf.raddr1 == 5'd0 |-> rf.rdata1 == '0
    );

endmodule

`default_nettype wire
